/* build.f */
+incdir+source
source/bus_pkg.sv
source/fetch_pkg.sv
source/fetch_mem.sv
source/instr_fetch.sv
source/compressed_expander.sv
source/fetch_top.sv
tests/clk_gen.sv
tests/tb_fetch.sv

/* run.sh */
#!/bin/sh
# build and run the fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir

verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch \
    --Mdir "$obj" -f build.f
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

"./$obj/Vtb_fetch" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" "$log"; then
    exit 1
fi
exit 0

/* source/bus_pkg.sv */
`include "fetch_consts.svh"

package bus_pkg;

    // master to slave
    typedef struct packed {
        logic                      psel;
        logic                      penable;
        logic                      pwrite;
        logic [`FETCH_APB_AW-1:0]  paddr;
        logic [`FETCH_XLEN-1:0]    pwdata;
    } apb_req_t;

    // slave to master
    typedef struct packed {
        logic                      pready;
        logic [`FETCH_XLEN-1:0]    prdata;
        logic                      pslverr;
    } apb_rsp_t;

endpackage

/* source/compressed_expander.sv */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module compressed_expander (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    in_valid_i,
    input  logic [`FETCH_XLEN-1:0]  in_instr_i,
    input  logic [`FETCH_XLEN-1:0]  in_pc_i,
    output logic                    in_accept_o,
    input  fetch_pkg::jump_t        flush_i,
    output fetch_pkg::fetch_out_t   out_o,
    input  logic                    out_ready_i
);
    import fetch_pkg::*;

    localparam logic [6:0] OpImm   = 7'b0010011;
    localparam logic [6:0] OpReg   = 7'b0110011;
    localparam logic [6:0] OpLoad  = 7'b0000011;
    localparam logic [6:0] OpStore = 7'b0100011;
    localparam logic [6:0] OpJal   = 7'b1101111;

    fetch_out_t             out_q;
    logic [15:0]            c;
    logic                   is_c;
    logic [4:0]             rd;
    logic [4:0]             rs2;
    logic [4:0]             rdp;    // x8..x15 from the 3-bit fields
    logic [4:0]             rs1p;
    logic [11:0]            ci_imm;
    logic [11:0]            lsw_imm;
    logic [20:0]            cj_imm;
    logic [`FETCH_XLEN-1:0] exp_instr;
    logic                   exp_illegal;

    assign c    = in_instr_i[15:0];
    assign is_c = c[1:0] != 2'b11;
    assign rd   = c[11:7];
    assign rs2  = c[6:2];
    assign rdp  = {2'b01, c[4:2]};
    assign rs1p = {2'b01, c[9:7]};

    assign ci_imm  = {{6{c[12]}}, c[12], c[6:2]};
    assign lsw_imm = {5'b0, c[5], c[12:10], c[6], 2'b00};
    assign cj_imm  = {{9{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};

    always_comb begin
        exp_instr   = `FETCH_INSTR_NOP;
        exp_illegal = 1'b0;
        if (!is_c) begin
            exp_instr = in_instr_i;
        end else begin
            case ({c[15:13], c[1:0]})
                5'b000_01: exp_instr = {ci_imm, rd, 3'b000, rd, OpImm};      // c.addi
                5'b010_01: exp_instr = {ci_imm, 5'd0, 3'b000, rd, OpImm};    // c.li
                5'b101_01: begin                                             // c.j
                    exp_instr = {cj_imm[20], cj_imm[10:1], cj_imm[11], cj_imm[19:12],
                                 5'd0, OpJal};
                end
                5'b010_00: exp_instr = {lsw_imm, rs1p, 3'b010, rdp, OpLoad}; // c.lw
                5'b110_00: begin                                             // c.sw
                    exp_instr = {lsw_imm[11:5], rdp, rs1p, 3'b010, lsw_imm[4:0], OpStore};
                end
                5'b100_10: begin
                    // rs2 of zero is jr/jalr/ebreak, not handled
                    if (rs2 == 5'd0) begin
                        exp_illegal = 1'b1;
                    end else if (c[12]) begin
                        exp_instr = {7'b0, rs2, rd, 3'b000, rd, OpReg};      // c.add
                    end else begin
                        exp_instr = {7'b0, rs2, 5'd0, 3'b000, rd, OpReg};    // c.mv
                    end
                end
                default: exp_illegal = 1'b1; // includes the all-zero halfword
            endcase
        end
    end

    // one-entry output register
    assign in_accept_o = !out_q.valid || out_ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            out_q.valid <= 1'b0;
        end else if (flush_i.valid) begin
            out_q.valid <= 1'b0;
        end else if (in_accept_o) begin
            out_q.valid <= in_valid_i;
            if (in_valid_i) begin
                out_q.pc         <= in_pc_i;
                out_q.instr      <= exp_instr;
                out_q.compressed <= is_c;
                out_q.illegal    <= exp_illegal;
            end
        end
    end

    assign out_o = out_q;

endmodule

/* source/fetch_consts.svh */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// address and instruction width
`define FETCH_XLEN 32

// instruction memory depth in words, fetch wraps at this size
`define FETCH_MEM_WORDS 256

// addi x0,x0,0
`define FETCH_INSTR_NOP 32'h0000_0013

`define FETCH_APB_AW 12
`define FETCH_REG_CTRL 12'h400 // bit 0 is run
`define FETCH_REG_BOOT 12'h404

`endif

/* source/fetch_mem.sv */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_mem (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  bus_pkg::apb_req_t       apb_i,
    output bus_pkg::apb_rsp_t       apb_o,
    input  logic [`FETCH_XLEN-1:0]  fetch_addr_i,
    output fetch_pkg::instr_word_u  fetch_word_o,
    output logic                    fetch_ready_o,
    output logic                    run_o,
    output logic [`FETCH_XLEN-1:0]  boot_addr_o
);
    localparam int IdxW = $clog2(`FETCH_MEM_WORDS);
    localparam logic [`FETCH_APB_AW-1:0] MemTop = `FETCH_MEM_WORDS * 4;

    logic [`FETCH_XLEN-1:0] mem [`FETCH_MEM_WORDS];
    logic [`FETCH_XLEN-1:0] ctrl_q;
    logic [`FETCH_XLEN-1:0] boot_q;
    logic [`FETCH_XLEN-1:0] rdata;
    logic [IdxW-1:0]        apb_idx;
    logic                   access;
    logic                   is_mem;
    logic                   is_ctrl;
    logic                   is_boot;
    logic                   run;
    logic                   err;

    assign access  = apb_i.psel & apb_i.penable;
    assign is_mem  = apb_i.paddr < MemTop;
    assign is_ctrl = apb_i.paddr == `FETCH_REG_CTRL;
    assign is_boot = apb_i.paddr == `FETCH_REG_BOOT;
    assign apb_idx = apb_i.paddr[IdxW+1:2];
    assign run     = ctrl_q[0];

    // program may only change while stopped
    assign err = access & ((is_mem & apb_i.pwrite & run) | ~(is_mem | is_ctrl | is_boot));

    always_ff @(posedge clk_i) begin
        if (access && apb_i.pwrite && is_mem && !run) begin
            mem[apb_idx] <= apb_i.pwdata;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            ctrl_q <= '0;
            boot_q <= '0;
        end else if (access && apb_i.pwrite) begin
            if (is_ctrl) ctrl_q <= apb_i.pwdata;
            if (is_boot) boot_q <= apb_i.pwdata;
        end
    end

    always_comb begin
        rdata = '0; // unmapped reads as zero
        if (is_mem) begin
            rdata = mem[apb_idx];
        end else if (is_ctrl) begin
            rdata = ctrl_q;
        end else if (is_boot) begin
            rdata = boot_q;
        end
    end

    // no wait states
    assign apb_o = '{pready: 1'b1, prdata: rdata, pslverr: err};

    // fetch side, same-cycle read
    assign fetch_word_o.instr = mem[fetch_addr_i[IdxW+1:2]];
    assign fetch_ready_o      = run;
    assign run_o              = run;
    assign boot_addr_o        = {boot_q[`FETCH_XLEN-1:1], 1'b0}; // bit 0 ignored

endmodule

/* source/fetch_pkg.sv */
`include "fetch_consts.svh"

package fetch_pkg;

    typedef struct packed {
        logic [15:0] hi;
        logic [15:0] lo;
    } halves_t;

    // one memory word, either a whole instruction or two halfwords
    typedef union packed {
        logic [`FETCH_XLEN-1:0] instr;
        halves_t                half;
    } instr_word_u;

    typedef struct packed {
        logic                   valid;
        logic [`FETCH_XLEN-1:0] target; // halfword aligned
    } jump_t;

    typedef struct packed {
        logic                   valid;
        logic [`FETCH_XLEN-1:0] pc;
        logic [`FETCH_XLEN-1:0] instr;      // always 32-bit form
        logic                   compressed;
        logic                   illegal;
    } fetch_out_t;

endpackage

/* source/fetch_top.sv */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_top (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  bus_pkg::apb_req_t     apb_i,
    output bus_pkg::apb_rsp_t     apb_o,
    input  fetch_pkg::jump_t      jump_i,
    output fetch_pkg::fetch_out_t fetch_o,
    input  logic                  fetch_ready_i
);
    import fetch_pkg::*;

    logic [`FETCH_XLEN-1:0] word_addr;
    instr_word_u            word;
    logic                   word_ready;
    logic                   run;
    logic [`FETCH_XLEN-1:0] boot_addr;
    logic                   raw_valid;
    logic [`FETCH_XLEN-1:0] raw_instr;
    logic [`FETCH_XLEN-1:0] raw_pc;
    logic                   accept;

    fetch_mem u_mem (
        .clk_i,
        .rst_ni,
        .apb_i,
        .apb_o,
        .fetch_addr_i  (word_addr),
        .fetch_word_o  (word),
        .fetch_ready_o (word_ready),
        .run_o         (run),
        .boot_addr_o   (boot_addr)
    );

    instr_fetch u_fetch (
        .clk_i,
        .rst_ni,
        .run_i        (run),
        .boot_addr_i  (boot_addr),
        .word_i       (word),
        .word_ready_i (word_ready),
        .word_addr_o  (word_addr),
        .jump_i,
        .raw_valid_o  (raw_valid),
        .raw_instr_o  (raw_instr),
        .raw_pc_o     (raw_pc),
        .accept_i     (accept)
    );

    compressed_expander u_expander (
        .clk_i,
        .rst_ni,
        .in_valid_i  (raw_valid),
        .in_instr_i  (raw_instr),
        .in_pc_i     (raw_pc),
        .in_accept_o (accept),
        .flush_i     (jump_i),
        .out_o       (fetch_o),
        .out_ready_i (fetch_ready_i)
    );

endmodule

/* source/instr_fetch.sv */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module instr_fetch (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    run_i,
    input  logic [`FETCH_XLEN-1:0]  boot_addr_i,
    input  fetch_pkg::instr_word_u  word_i,
    input  logic                    word_ready_i,
    output logic [`FETCH_XLEN-1:0]  word_addr_o,
    input  fetch_pkg::jump_t        jump_i,
    output logic                    raw_valid_o,
    output logic [`FETCH_XLEN-1:0]  raw_instr_o,
    output logic [`FETCH_XLEN-1:0]  raw_pc_o,
    input  logic                    accept_i
);
    import fetch_pkg::*;

    typedef enum logic [1:0] {
        ALIGNED,            // next instr starts at low half
        UNALIGNED,          // compressed instr in high half
        INIT_UNALIGNED,     // just started at a halfword target
        UNALIGNED_CONTINUE  // low part of a 32-bit instr held in buf_q
    } if_state_e;

    if_state_e              state_q;
    if_state_e              state_d;
    logic [`FETCH_XLEN-1:0] addr_q;     // word fetch address
    logic [`FETCH_XLEN-1:0] pc_q;       // true instruction pc
    logic [15:0]            buf_q;
    instr_word_u            raw;
    logic                   low_c;
    logic                   high_c;
    logic                   raw_c;
    logic                   jump_phase;
    logic                   take;
    logic                   advance;
    logic                   addr_inc;

    assign low_c  = word_i.half.lo[1:0] != 2'b11;
    assign high_c = word_i.half.hi[1:0] != 2'b11;

    // upper halfword of a 32-bit instr at the target goes to the buffer first
    assign jump_phase  = (state_q == INIT_UNALIGNED) && !high_c;
    assign raw_valid_o = word_ready_i && !jump_phase;
    assign take        = raw_valid_o && accept_i;
    assign advance     = take || (jump_phase && word_ready_i);

    always_comb begin
        raw = '0;
        case (state_q)
            ALIGNED: begin
                if (low_c) begin
                    raw.half.lo = word_i.half.lo;
                end else begin
                    raw.instr = word_i.instr;
                end
            end
            UNALIGNED, INIT_UNALIGNED: begin
                raw.half.lo = word_i.half.hi;
            end
            default: begin // joined across the word boundary
                raw.half.hi = word_i.half.lo;
                raw.half.lo = buf_q;
            end
        endcase
    end

    assign raw_c       = raw.half.lo[1:0] != 2'b11;
    assign raw_instr_o = raw.instr;
    assign raw_pc_o    = pc_q;
    assign word_addr_o = addr_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ALIGNED: begin
                if (!low_c) state_d = ALIGNED;
                else if (high_c) state_d = UNALIGNED;
                else state_d = UNALIGNED_CONTINUE;
            end
            UNALIGNED: begin
                state_d = ALIGNED;
            end
            INIT_UNALIGNED: begin
                state_d = high_c ? ALIGNED : UNALIGNED_CONTINUE;
            end
            default: begin
                state_d = high_c ? UNALIGNED : UNALIGNED_CONTINUE;
            end
        endcase
    end

    // the word is used up unless a compressed instr remains in its high half
    assign addr_inc = state_d != UNALIGNED;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= ALIGNED;
            addr_q  <= '0;
            pc_q    <= '0;
        end else if (jump_i.valid) begin
            state_q <= jump_i.target[1] ? INIT_UNALIGNED : ALIGNED;
            addr_q  <= {jump_i.target[`FETCH_XLEN-1:2], 2'b00};
            pc_q    <= {jump_i.target[`FETCH_XLEN-1:1], 1'b0};
        end else if (!run_i) begin
            // parked at boot until run
            state_q <= boot_addr_i[1] ? INIT_UNALIGNED : ALIGNED;
            addr_q  <= {boot_addr_i[`FETCH_XLEN-1:2], 2'b00};
            pc_q    <= {boot_addr_i[`FETCH_XLEN-1:1], 1'b0};
        end else if (advance) begin
            state_q <= state_d;
            if (addr_inc) addr_q <= addr_q + 4;
            if (take) pc_q <= raw_c ? pc_q + 2 : pc_q + 4;
        end
    end

    always_ff @(posedge clk_i) begin
        if (advance && state_d == UNALIGNED_CONTINUE) begin
            buf_q <= word_i.half.hi;
        end
    end

endmodule

/* tests/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen (
    output logic clk_o,
    output logic rst_n_o
);
    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o; // 8 ns period
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (10) @(posedge clk_o);
        #1;
        rst_n_o = 1'b1;
    end

endmodule

/* tests/tb_fetch.sv */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module tb_fetch;
    import bus_pkg::*;
    import fetch_pkg::*;

    localparam int timeout_cycles = 200;

    logic        clk;
    logic        rst_n;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    jump_t       jump;
    fetch_out_t  fetch_out;
    logic        fetch_ready;
    logic [31:0] image [`FETCH_MEM_WORDS]; // expected memory contents
    logic [31:0] prog_ptr;
    bit          random_ready;

    clk_gen u_clk (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    fetch_top uut (
        .clk_i         (clk),
        .rst_ni        (rst_n),
        .apb_i         (apb_req),
        .apb_o         (apb_rsp),
        .jump_i        (jump),
        .fetch_o       (fetch_out),
        .fetch_ready_i (fetch_ready)
    );

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic die(string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_val(string name, logic [95:0] exp, logic [95:0] act);
        assert (act === exp) else die($sformatf("ERR %s expected %h got %h", name, exp, act));
    endtask

    task automatic apb_xfer(bit wr, logic [11:0] addr, logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        int n;
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        #1;
        check_val("pslverr", 96'd0, apb_rsp.pslverr); // setup phase
        step();
        apb_req.penable = 1'b1;
        #1;
        for (n = 0; n < timeout_cycles && !apb_rsp.pready; n++) begin
            step();
            #1;
        end
        if (!apb_rsp.pready) die("timeout waiting for APB pready");
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        step();
        apb_req = '0;
    endtask

    task automatic apb_write(logic [11:0] addr, logic [31:0] data, logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b1, addr, data, rdata, err);
        check_val("pslverr", exp_err, err);
    endtask

    task automatic apb_read(logic [11:0] addr, logic [31:0] exp, logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b0, addr, '0, rdata, err);
        check_val("pslverr", exp_err, err);
        check_val("prdata", exp, rdata);
    endtask

    function automatic logic [31:0] fill_word(int i);
        logic [7:0] b;
        b = 8'(i);
        return {b, ~b, 8'h05, 8'h13}; // 32-bit encoding at every word
    endfunction

    function automatic logic [15:0] half_at(logic [31:0] a);
        logic [31:0] w;
        w = image[(a >> 2) % `FETCH_MEM_WORDS];
        return a[1] ? w[31:16] : w[15:0];
    endfunction

    // RVC subset expanded to RV32I
    function automatic logic [31:0] expand16(logic [15:0] h, output logic bad);
        logic [31:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rs2;
        logic [4:0]  rdp;
        logic [4:0]  rs1p;
        rd   = h[11:7];
        rs2  = h[6:2];
        rdp  = 5'd8 + 5'(h[4:2]);
        rs1p = 5'd8 + 5'(h[9:7]);
        bad  = 1'b0;
        if (h[1:0] == 2'b01 && (h[15:13] == 3'd0 || h[15:13] == 3'd2)) begin
            imm = {{27{h[12]}}, h[6:2]};
            return {imm[11:0], ((h[15:13] == 3'd0) ? rd : 5'd0), 3'd0, rd, 7'h13};
        end
        if (h[1:0] == 2'b01 && h[15:13] == 3'd5) begin
            imm = 32'(h[5:3]) << 1 | 32'(h[11]) << 4 | 32'(h[2]) << 5 | 32'(h[7]) << 6
                | 32'(h[6]) << 7 | 32'(h[10:9]) << 8 | 32'(h[8]) << 10;
            if (h[12]) imm = imm | 32'hffff_f800;
            return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, 7'h6f};
        end
        if (h[1:0] == 2'b00 && (h[15:13] == 3'd2 || h[15:13] == 3'd6)) begin
            imm = 32'(h[5]) << 6 | 32'(h[12:10]) << 3 | 32'(h[6]) << 2;
            if (h[15]) return {imm[11:5], rdp, rs1p, 3'd2, imm[4:0], 7'h23};
            return {imm[11:0], rs1p, 3'd2, rdp, 7'h03};
        end
        if (h[1:0] == 2'b10 && h[15:13] == 3'd4 && rs2 != 5'd0) begin
            return {7'd0, rs2, (h[12] ? rd : 5'd0), 3'd0, rd, 7'h33};
        end
        bad = 1'b1;
        return `FETCH_INSTR_NOP;
    endfunction

    // waits for the next transfer and checks it, then moves pc past it
    task automatic expect_fetch(inout logic [31:0] pc);
        fetch_out_t  exp;
        fetch_out_t  held;
        logic        holding;
        logic        bad;
        logic [15:0] h;
        int          n;
        h = half_at(pc);
        exp = '{valid: 1'b1, pc: pc, instr: '0, compressed: h[1:0] != 2'b11, illegal: 1'b0};
        bad = 1'b0;
        if (exp.compressed) exp.instr = expand16(h, bad);
        else exp.instr = {half_at(pc + 2), h};
        exp.illegal = bad;
        holding = 1'b0;
        for (n = 0; n < timeout_cycles; n++) begin
            if (holding) check_val("fetch_o held", held, fetch_out);
            fetch_ready = random_ready ? 1'($urandom) : 1'b1;
            if (fetch_out.valid && fetch_ready) break;
            holding = fetch_out.valid;
            held    = fetch_out;
            step();
        end
        if (!(fetch_out.valid && fetch_ready)) die("timeout waiting for a fetch output");
        check_val("fetch_o.pc", exp.pc, fetch_out.pc);
        check_val("fetch_o.instr", exp.instr, fetch_out.instr);
        check_val("fetch_o.compressed", exp.compressed, fetch_out.compressed);
        check_val("fetch_o.illegal", exp.illegal, fetch_out.illegal);
        step();
        pc = pc + (exp.compressed ? 32'd2 : 32'd4);
    endtask

    task automatic run_stream(logic [31:0] start, int count);
        logic [31:0] pc;
        pc = start;
        repeat (count) expect_fetch(pc);
    endtask

    task automatic start_run(logic [31:0] boot);
        apb_write(`FETCH_REG_BOOT, boot, 1'b0);
        apb_write(`FETCH_REG_CTRL, 32'd1, 1'b0);
    endtask

    task automatic stop_run();
        fetch_ready = 1'b0;
        apb_write(`FETCH_REG_CTRL, 32'd0, 1'b0);
        fetch_ready = 1'b1; // drain whatever is left
        repeat (2) step();
        repeat (8) begin
            assert (!fetch_out.valid) else die("fetch output valid after run was cleared");
            step();
        end
    endtask

    task automatic jump_to(logic [31:0] target);
        fetch_ready = 1'b0; // nothing transfers in the jump cycle
        jump = '{valid: 1'b1, target: target};
        step();
        jump = '0;
    endtask

    task automatic put16(logic [15:0] h);
        if (prog_ptr[1]) image[(prog_ptr >> 2) % `FETCH_MEM_WORDS][31:16] = h;
        else image[(prog_ptr >> 2) % `FETCH_MEM_WORDS][15:0] = h;
        prog_ptr = prog_ptr + 2;
    endtask

    task automatic put32(logic [31:0] w);
        put16(w[15:0]);
        put16(w[31:16]);
    endtask

    task automatic push_image(logic [31:0] first, logic [31:0] last);
        logic [31:0] a;
        for (a = first; a <= last; a = a + 4) begin
            apb_write(a[11:0], image[(a >> 2) % `FETCH_MEM_WORDS], 1'b0);
        end
    endtask

    initial begin
        logic [31:0] pc;
        logic [31:0] rnd;
        int          n;
        void'($urandom(32'h45696eb3));
        apb_req      = '0;
        jump         = '0;
        fetch_ready  = 1'b0;
        random_ready = 1'b0;
        prog_ptr     = '0;
        for (n = 0; n < timeout_cycles && !rst_n; n++) step();
        if (!rst_n) die("reset was never released");
        check_val("fetch_o.valid", 96'd0, fetch_out.valid);

        // registers and memory over APB
        apb_read(`FETCH_REG_CTRL, 32'd0, 1'b0);
        apb_read(`FETCH_REG_BOOT, 32'd0, 1'b0);
        for (n = 0; n < `FETCH_MEM_WORDS; n++) image[n] = fill_word(n);
        push_image(32'h0, (`FETCH_MEM_WORDS - 1) * 4);
        for (n = 0; n < `FETCH_MEM_WORDS; n++) apb_read(12'(n * 4), image[n], 1'b0);
        rnd = $urandom;
        apb_write(`FETCH_REG_BOOT, rnd, 1'b0);
        apb_read(`FETCH_REG_BOOT, rnd, 1'b0);
        rnd = $urandom & ~32'd1; // keep run clear
        apb_write(`FETCH_REG_CTRL, rnd, 1'b0);
        apb_read(`FETCH_REG_CTRL, rnd, 1'b0);
        apb_write(`FETCH_REG_CTRL, 32'd0, 1'b0);
        apb_read(12'h408, 32'd0, 1'b1);
        apb_write(12'h800, rnd, 1'b1);
        start_run(32'h0);
        apb_write(12'h014, ~image[5], 1'b1);
        apb_read(12'h014, image[5], 1'b0);
        stop_run();

        // straight 32-bit code from address 0, one output per cycle
        start_run(32'h0);
        pc = 32'h0;
        expect_fetch(pc);
        repeat (23) begin
            assert (fetch_out.valid) else die("gap in a stream of single-word instructions");
            expect_fetch(pc);
        end
        stop_run();

        // mixed program with a halfword boot address
        prog_ptr = 32'h102;
        put32(32'h00a5_0513); // crosses into the next word
        put16(16'h0515);      // c.addi
        put16(16'h55f5);      // c.li
        put32(32'h0085_2603); // lw, crosses a word
        put16(16'h86b2);      // c.mv
        put32(32'h00c6_8733);
        put16(16'h9736);      // c.add
        put16(16'h4044);      // c.lw
        put16(16'hc404);      // c.sw
        put16(16'hbfe5);      // c.j
        put32(32'h0080_006f);
        push_image(32'h100, 32'h11c);
        start_run(32'h102);
        run_stream(32'h102, 15);
        stop_run();

        // jumps while streaming
        start_run(32'h102);
        pc = 32'h102;
        repeat (3) expect_fetch(pc);
        jump_to(32'h110);
        pc = 32'h110;
        repeat (4) expect_fetch(pc);
        jump_to(32'h10a); // 32-bit instr split over two words
        pc = 32'h10a;
        repeat (6) expect_fetch(pc);
        stop_run();

        // same program with random back-pressure
        random_ready = 1'b1;
        start_run(32'h102);
        run_stream(32'h102, 15);
        random_ready = 1'b0;
        stop_run();

        // reserved encodings in between legal ones
        prog_ptr = 32'h200;
        put16(16'h0000);
        put16(16'h0515);
        put16(16'h8002);      // c.jr shape is outside the subset
        put16(16'h2001);      // c.jal
        put32(32'h00c6_8733);
        put16(16'h6505);      // c.lui
        put16(16'h55f5);
        push_image(32'h200, 32'h20c);
        start_run(32'h200);
        run_stream(32'h200, 9);
        stop_run();

        $display("all tests passed");
        $finish;
    end

endmodule
